// ==== list.f ====
+incdir+design
design/icache_pkg.sv
design/icache_fetch_stage.sv
design/icache_arrays.sv
design/icache_refill.sv
design/icache_top.sv
verif/icache_assertions.sv
verif/icache_tb.sv

// ==== Makefile ====
TOP = icache_tb

all: run

run:
	verilator --binary --timing --assert -f list.f --top-module $(TOP) -Mdir obj_dir
	-./obj_dir/V$(TOP) > sim.log 2>&1
	cat sim.log
	grep -q "STATUS: PASS" sim.log

lint:
	verilator --lint-only --timing --assert -f list.f --top-module $(TOP)

clean:
	rm -rf obj_dir sim.log

.PHONY: all run lint clean

// ==== verif/icache_tb.sv ====
// icache testbench with random fetch traffic, a burst memory model and a reference cache model
`timescale 1ns/1ns

module icache_tb import icache_pkg::*; ();

  localparam int CLK_PERIOD = 100;
  localparam int NUM_REQ    = 200;

  logic   clk;
  logic   rst_n;
  logic   req_valid_i;
  addr_t  req_addr_i;
  logic   req_ready_o;
  logic   rsp_valid_o;
  addr_t  rsp_addr_o;
  instr_t rsp_instr_o;
  logic   rsp_ready_i;
  logic   ar_valid_o;
  addr_t  ar_addr_o;
  logic   ar_ready_i;
  logic   r_valid_i;
  instr_t r_data_i;
  logic   r_last_i;
  logic   r_ready_o;

  addr_t       req_list [NUM_REQ];
  addr_t       addr_q [$];
  int unsigned exp_miss;
  int unsigned burst_cnt;
  int unsigned rsp_cnt;

  // reference cache state
  logic [23:0] ref_tag   [16][2];
  logic        ref_valid [16][2];
  logic        ref_repl  [16];

  icache_top dut_i (.*);

  initial begin
    clk = 1'b0;
    forever #(CLK_PERIOD / 2) clk = ~clk;
  end

  // ==========================================================================
  // reference functions and checks
  // ==========================================================================
  function automatic instr_t mem_word(input addr_t a);
    return (a * 32'h9e3779b1) ^ {a[15:0], a[31:16]} ^ 32'h5a5a0f0f;
  endfunction

  // returns 1 on a hit and fills the victim on a miss
  function automatic bit ref_lookup(input addr_t a);
    logic [3:0] idx;
    bit         hit;
    logic       way;
    idx = a[7:4];
    hit = 1'b0;
    way = 1'b0;
    for (int w = 0; w < 2; w++) begin
      if (!hit && ref_valid[idx][w] && ref_tag[idx][w] == a[31:8]) begin
        hit = 1'b1;
        way = w[0];
      end
    end
    if (!hit) begin
      way = ref_repl[idx];
      ref_valid[idx][way] = 1'b1;
      ref_tag[idx][way]   = a[31:8];
    end
    // victim pointer moves off the way just used
    if (ref_repl[idx] == way) ref_repl[idx] = ~way;
    return hit;
  endfunction

  // six lines with three per set, more than two ways can hold
  function automatic addr_t pick_addr();
    int unsigned line_sel;
    logic [3:0]  set;
    line_sel = $urandom_range(5);
    set      = (line_sel < 3) ? 4'h3 : 4'h9;
    return {24'h00a000 + 24'(line_sel), set, 2'($urandom_range(3)), 2'b00};
  endfunction

  task automatic abort_run(input string why);
    $display("%s", why);
    $display("STATUS: FAIL");
    $fatal(1, "simulation stopped on the first error");
  endtask

  task automatic check_eq(input string name, input logic [31:0] got, input logic [31:0] exp);
    if (got !== exp) begin
      abort_run($sformatf("[FAIL] t=%0t %s got=%h exp=%h", $time, name, got, exp));
    end
  endtask

  // ==========================================================================
  // stimulus
  // ==========================================================================
  initial begin : stimulus
    logic taken;
    void'($urandom(32'h68f65e55));
    rst_n       = 1'b0;
    req_valid_i = 1'b0;
    req_addr_i  = '0;
    burst_cnt   = 0;
    rsp_cnt     = 0;
    exp_miss    = 0;
    for (int s = 0; s < 16; s++) begin
      ref_repl[s]     = 1'b0;
      ref_valid[s][0] = 1'b0;
      ref_valid[s][1] = 1'b0;
    end
    for (int i = 0; i < NUM_REQ; i++) begin
      req_list[i] = pick_addr();
      if (!ref_lookup(req_list[i])) exp_miss++;
    end

    repeat (8) @(negedge clk);
    rst_n = 1'b1;
    @(negedge clk);
    #(CLK_PERIOD / 4);
    check_eq("req_ready_o", req_ready_o, 1);
    check_eq("rsp_valid_o", rsp_valid_o, 0);
    check_eq("ar_valid_o", ar_valid_o, 0);
    check_eq("r_ready_o", r_ready_o, 0);
    @(negedge clk);

    for (int i = 0; i < NUM_REQ; i++) begin
      if ($urandom_range(3) == 0) begin
        req_valid_i = 1'b0;
        @(negedge clk);
      end
      req_valid_i = 1'b1;
      req_addr_i  = req_list[i];
      // ready is sampled ahead of the rising edge that takes the request
      do begin
        #(CLK_PERIOD / 4);
        taken = req_ready_o;
        @(negedge clk);
      end while (!taken);
    end
    req_valid_i = 1'b0;

    while (rsp_cnt < NUM_REQ) @(negedge clk);
    $display("%0d requests, %0d bursts, %0d expected misses", NUM_REQ, burst_cnt, exp_miss);
    if (burst_cnt == exp_miss && dut_i.u_assert.err_cnt == 0) begin
      $display("STATUS: PASS");
      $finish;
    end else begin
      check_eq("assert_err_cnt", dut_i.u_assert.err_cnt, 0);
      check_eq("burst_cnt", burst_cnt, exp_miss);
    end
  end

  initial begin : consumer
    rsp_ready_i = 1'b0;
    forever begin
      @(negedge clk);
      // low in about 30% of cycles
      rsp_ready_i = ($urandom_range(9) >= 3);
    end
  end

  initial begin : memory_model
    addr_t line_addr;
    logic  taken;
    ar_ready_i = 1'b0;
    r_valid_i  = 1'b0;
    r_data_i   = '0;
    r_last_i   = 1'b0;
    forever begin
      @(negedge clk);
      if (rst_n && ar_valid_o) begin
        if (addr_q.size() == 0) abort_run("burst request seen with no fetch outstanding");
        line_addr = ar_addr_o;
        check_eq("ar_addr_o", ar_addr_o, {addr_q[0][31:4], 4'h0});
        repeat ($urandom_range(3)) @(negedge clk);
        ar_ready_i = 1'b1;
        @(negedge clk);
        ar_ready_i = 1'b0;
        burst_cnt++;
        for (int b = 0; b < 4; b++) begin
          repeat ($urandom_range(2)) @(negedge clk);
          r_valid_i = 1'b1;
          r_data_i  = mem_word(line_addr + 32'(4 * b));
          r_last_i  = (b == 3);
          // beat stays up until the cache takes it
          do begin
            #(CLK_PERIOD / 4);
            taken = r_ready_o;
            @(negedge clk);
          end while (!taken);
          r_valid_i = 1'b0;
          r_last_i  = 1'b0;
        end
      end
    end
  end

  // ==========================================================================
  // compare
  // ==========================================================================
  initial begin : compare
    logic   held;
    addr_t  held_addr;
    instr_t held_instr;
    addr_t  exp_addr;
    held = 1'b0;
    forever begin
      @(negedge clk);
      // values that the next rising edge will take
      #(CLK_PERIOD / 4);
      check_eq("assert_err_cnt", dut_i.u_assert.err_cnt, 0);
      if (held) begin
        check_eq("rsp_valid_o", rsp_valid_o, 1);
        check_eq("rsp_addr_o", rsp_addr_o, held_addr);
        check_eq("rsp_instr_o", rsp_instr_o, held_instr);
      end
      held       = rst_n && rsp_valid_o && !rsp_ready_i;
      held_addr  = rsp_addr_o;
      held_instr = rsp_instr_o;
      if (rst_n && rsp_valid_o && rsp_ready_i) begin
        if (addr_q.size() == 0) abort_run("response seen with no fetch outstanding");
        exp_addr = addr_q.pop_front();
        check_eq("rsp_addr_o", rsp_addr_o, exp_addr);
        check_eq("rsp_instr_o", rsp_instr_o, mem_word(exp_addr));
        rsp_cnt++;
      end
      if (rst_n && req_valid_i && req_ready_o) addr_q.push_back(req_addr_i);
    end
  end

  // worst miss plus back-pressure stays well under 40 cycles
  initial begin : watchdog
    #((NUM_REQ * 40 + 20) * CLK_PERIOD);
    abort_run("timeout: responses stopped arriving, the run hung");
  end

endmodule

// ==== verif/icache_assertions.sv ====
// icache checker for read-address hold, response stability and refill phase exclusion
`timescale 1ns/1ns

module icache_assertions import icache_pkg::*; (
  input logic   clk,
  input logic   rst_n,
  input logic   ar_valid_o,
  input addr_t  ar_addr_o,
  input logic   ar_ready_i,
  input logic   r_ready_o,
  input logic   rsp_valid_o,
  input addr_t  rsp_addr_o,
  input instr_t rsp_instr_o,
  input logic   rsp_ready_i
);

  int unsigned err_cnt = 0;

  // burst request stays up with the same line until the memory takes it
  a_ar_hold: assert property (@(posedge clk) disable iff (!rst_n)
    ar_valid_o && !ar_ready_i |=> ar_valid_o && $stable(ar_addr_o))
    else begin
      $error("ar_valid_o dropped or ar_addr_o moved before ar_ready_i");
      err_cnt++;
    end

  a_rsp_hold: assert property (@(posedge clk) disable iff (!rst_n)
    rsp_valid_o && !rsp_ready_i |=> rsp_valid_o && $stable(rsp_addr_o) && $stable(rsp_instr_o))
    else begin
      $error("response changed while rsp_ready_i was low");
      err_cnt++;
    end

  // request and data phases never overlap each other or a response
  a_ar_r_excl: assert property (@(posedge clk) disable iff (!rst_n)
    !(ar_valid_o && r_ready_o) &&
    !(rsp_valid_o && (ar_valid_o || r_ready_o)))
    else begin
      $error("ar_valid_o, r_ready_o and rsp_valid_o overlap");
      err_cnt++;
    end

endmodule

bind icache_top icache_assertions u_assert (
  .clk         (clk),
  .rst_n       (rst_n),
  .ar_valid_o  (ar_valid_o),
  .ar_addr_o   (ar_addr_o),
  .ar_ready_i  (ar_ready_i),
  .r_ready_o   (r_ready_o),
  .rsp_valid_o (rsp_valid_o),
  .rsp_addr_o  (rsp_addr_o),
  .rsp_instr_o (rsp_instr_o),
  .rsp_ready_i (rsp_ready_i)
);

// ==== design/icache_top.sv ====
// icache top: two-way read-only instruction cache with burst refill
`timescale 1ns/1ns
`include "icache_consts.svh"

module icache_top import icache_pkg::*; (
  input  logic   clk,
  input  logic   rst_n,
  input  logic   req_valid_i,
  input  addr_t  req_addr_i,
  output logic   req_ready_o,
  output logic   rsp_valid_o,
  output addr_t  rsp_addr_o,
  output instr_t rsp_instr_o,
  input  logic   rsp_ready_i,
  output logic   ar_valid_o,
  output addr_t  ar_addr_o,
  input  logic   ar_ready_i,
  input  logic   r_valid_i,
  input  instr_t r_data_i,
  input  logic   r_last_i,
  output logic   r_ready_o
);

  tag_t  [`ICACHE_WAY_NUM-1:0] way_tag;
  logic  [`ICACHE_WAY_NUM-1:0] way_valid;
  line_t [`ICACHE_WAY_NUM-1:0] way_line;
  way_t                        repl_bit;
  idx_t                        rd_idx;
  logic                        repl_we;
  way_t                        repl_wdata;
  logic                        s1_valid;
  addr_t                       s1_addr;
  logic                        lookup_miss;
  logic                        refill_idle;
  logic                        fill_we;
  way_t                        fill_way;
  line_t                       fill_line;

  icache_fetch_stage u_fetch (
    .clk, .rst_n,
    .req_valid_i, .req_addr_i, .req_ready_o,
    .rsp_valid_o, .rsp_addr_o, .rsp_instr_o, .rsp_ready_i,
    .refill_idle_i (refill_idle),
    .way_tag_i     (way_tag),
    .way_valid_i   (way_valid),
    .way_line_i    (way_line),
    .repl_bit_i    (repl_bit),
    .rd_idx_o      (rd_idx),
    .repl_we_o     (repl_we),
    .repl_wdata_o  (repl_wdata),
    .s1_valid_o    (s1_valid),
    .s1_addr_o     (s1_addr),
    .lookup_miss_o (lookup_miss)
  );

  icache_arrays u_arrays (
    .clk, .rst_n,
    .rd_idx_i     (rd_idx),
    .fill_we_i    (fill_we),
    .fill_way_i   (fill_way),
    .fill_addr_i  (s1_addr),
    .fill_line_i  (fill_line),
    .repl_we_i    (repl_we),
    .repl_wdata_i (repl_wdata),
    .way_tag_o    (way_tag),
    .way_valid_o  (way_valid),
    .way_line_o   (way_line),
    .repl_bit_o   (repl_bit)
  );

  icache_refill u_refill (
    .clk, .rst_n,
    .s1_valid_i    (s1_valid),
    .s1_addr_i     (s1_addr),
    .lookup_miss_i (lookup_miss),
    .repl_bit_i    (repl_bit),
    .refill_idle_o (refill_idle),
    .ar_valid_o, .ar_addr_o, .ar_ready_i,
    .r_valid_i, .r_data_i, .r_last_i, .r_ready_o,
    .fill_we_o     (fill_we),
    .fill_way_o    (fill_way),
    .fill_line_o   (fill_line)
  );

endmodule

// ==== design/icache_refill.sv ====
// icache memory side: miss FSM, line burst request, beat buffer and line fill
`timescale 1ns/1ns
`include "icache_consts.svh"

module icache_refill import icache_pkg::*; (
  input  logic   clk,
  input  logic   rst_n,
  // from the fetch stage
  input  logic   s1_valid_i,
  input  addr_t  s1_addr_i,
  input  logic   lookup_miss_i,
  input  way_t   repl_bit_i,
  output logic   refill_idle_o,
  // read address channel
  output logic   ar_valid_o,
  output addr_t  ar_addr_o,
  input  logic   ar_ready_i,
  // read data channel
  input  logic   r_valid_i,
  input  instr_t r_data_i,
  input  logic   r_last_i,
  output logic   r_ready_o,
  // line fill into the arrays
  output logic   fill_we_o,
  output way_t   fill_way_o,
  output line_t  fill_line_o
);

  refill_state_e state;
  word_sel_t     beat_idx;
  instr_t        beat_buf [0:`ICACHE_LINE_WORDS-2];
  logic          beat_fire;

  assign beat_fire = r_valid_i && r_ready_o;

  // ==========================================================================
  // miss FSM
  // ==========================================================================
  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      state <= REFILL_IDLE;
    end else begin
      case (state)
        REFILL_IDLE:  if (s1_valid_i && lookup_miss_i) state <= REFILL_MISS;
        REFILL_MISS:  if (ar_ready_i) state <= REFILL_BURST;
        REFILL_BURST: if (r_valid_i && r_last_i) state <= REFILL_IDLE;
        default:      state <= REFILL_IDLE;
      endcase
    end
  end

  assign refill_idle_o = (state == REFILL_IDLE);
  assign ar_valid_o    = (state == REFILL_MISS);
  assign r_ready_o     = (state == REFILL_BURST);

  // stage 1 holds during the miss, so the address stays put
  assign ar_addr_o = {s1_addr_i[`ICACHE_ADDR_W-1:`ICACHE_OFS_W], {`ICACHE_OFS_W{1'b0}}};

  // ==========================================================================
  // beat collection
  // ==========================================================================
  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      beat_idx <= '0;
    end else if (state != REFILL_BURST) begin
      beat_idx <= '0;
    end else if (beat_fire) begin
      beat_idx <= beat_idx + 1'b1;
    end
  end

  // last beat goes straight into the line
  always_ff @(posedge clk) begin
    if (beat_fire && !r_last_i) begin
      beat_buf[beat_idx] <= r_data_i;
    end
  end

  always_comb begin
    for (int w = 0; w < `ICACHE_LINE_WORDS - 1; w++) begin
      fill_line_o[w*32 +: 32] = beat_buf[w];
    end
    fill_line_o[(`ICACHE_LINE_WORDS-1)*32 +: 32] = r_data_i;
  end

  assign fill_we_o  = beat_fire && r_last_i;
  assign fill_way_o = repl_bit_i;

endmodule

// ==== design/icache_arrays.sv ====
// icache storage: per-way tag, valid and data plus per-set replacement bits
`timescale 1ns/1ns
`include "icache_consts.svh"

module icache_arrays import icache_pkg::*; (
  input  logic                           clk,
  input  logic                           rst_n,
  input  idx_t                           rd_idx_i,
  // line fill, set and tag come from fill_addr_i
  input  logic                           fill_we_i,
  input  way_t                           fill_way_i,
  input  addr_t                          fill_addr_i,
  input  line_t                          fill_line_i,
  // replacement bit update, same set as the fill address
  input  logic                           repl_we_i,
  input  way_t                           repl_wdata_i,
  output tag_t  [`ICACHE_WAY_NUM-1:0]    way_tag_o,
  output logic  [`ICACHE_WAY_NUM-1:0]    way_valid_o,
  output line_t [`ICACHE_WAY_NUM-1:0]    way_line_o,
  output way_t                           repl_bit_o
);

  idx_t wr_idx;
  tag_t wr_tag;
  logic wr_same_set;

  assign wr_idx      = fill_addr_i[`ICACHE_OFS_W +: `ICACHE_IDX_W];
  assign wr_tag      = fill_addr_i[`ICACHE_ADDR_W-1 -: `ICACHE_TAG_W];
  assign wr_same_set = (wr_idx == rd_idx_i);

  // ==========================================================================
  // per-way storage
  // ==========================================================================
  for (genvar w = 0; w < `ICACHE_WAY_NUM; w++) begin : gen_way
    tag_t                     tag_mem  [`ICACHE_SETS];
    line_t                    data_mem [`ICACHE_SETS];
    logic [`ICACHE_SETS-1:0]  valid_bits;
    logic                     way_we;

    assign way_we = fill_we_i && (fill_way_i == way_t'(w));

    // write-first, a fill to the set being read shows up at once
    always_ff @(posedge clk) begin
      if (way_we) begin
        tag_mem[wr_idx]  <= wr_tag;
        data_mem[wr_idx] <= fill_line_i;
      end
      if (way_we && wr_same_set) begin
        way_tag_o[w]  <= wr_tag;
        way_line_o[w] <= fill_line_i;
      end else begin
        way_tag_o[w]  <= tag_mem[rd_idx_i];
        way_line_o[w] <= data_mem[rd_idx_i];
      end
    end

    always_ff @(posedge clk or negedge rst_n) begin
      if (!rst_n) begin
        valid_bits     <= '0;
        way_valid_o[w] <= 1'b0;
      end else begin
        if (way_we) begin
          valid_bits[wr_idx] <= 1'b1;
        end
        way_valid_o[w] <= (way_we && wr_same_set) || valid_bits[rd_idx_i];
      end
    end
  end

  // ==========================================================================
  // replacement bits
  // ==========================================================================
  logic [`ICACHE_SETS-1:0] repl_bits;

  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      repl_bits  <= '0;
      repl_bit_o <= '0;
    end else begin
      if (repl_we_i) begin
        repl_bits[wr_idx] <= repl_wdata_i;
      end
      repl_bit_o <= (repl_we_i && wr_same_set) ? repl_wdata_i : repl_bits[rd_idx_i];
    end
  end

endmodule

// ==== design/icache_fetch_stage.sv ====
// icache request side with the stage 1 register, tag match, hit response and replacement update
`timescale 1ns/1ns
`include "icache_consts.svh"

module icache_fetch_stage import icache_pkg::*; (
  input  logic                           clk,
  input  logic                           rst_n,
  // fetch request
  input  logic                           req_valid_i,
  input  addr_t                          req_addr_i,
  output logic                           req_ready_o,
  // response
  output logic                           rsp_valid_o,
  output addr_t                          rsp_addr_o,
  output instr_t                         rsp_instr_o,
  input  logic                           rsp_ready_i,
  // refill status
  input  logic                           refill_idle_i,
  // array read results
  input  tag_t  [`ICACHE_WAY_NUM-1:0]    way_tag_i,
  input  logic  [`ICACHE_WAY_NUM-1:0]    way_valid_i,
  input  line_t [`ICACHE_WAY_NUM-1:0]    way_line_i,
  input  way_t                           repl_bit_i,
  // array control
  output idx_t                           rd_idx_o,
  output logic                           repl_we_o,
  output way_t                           repl_wdata_o,
  // to refill
  output logic                           s1_valid_o,
  output addr_t                          s1_addr_o,
  output logic                           lookup_miss_o
);

  logic                       s1_valid;
  addr_t                      s1_addr;
  logic                       s1_ready;
  tag_t                       s1_tag;
  word_sel_t                  s1_word;
  logic [`ICACHE_WAY_NUM-1:0] way_match;
  logic                       hit;
  way_t                       hit_way;
  line_t                      hit_line;

  // ==========================================================================
  // stage 1 register
  // ==========================================================================

  // empty or handing a hit to the consumer this cycle
  assign s1_ready = refill_idle_i && (!s1_valid || (hit && rsp_ready_i));

  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      s1_valid <= 1'b0;
    end else if (s1_ready) begin
      s1_valid <= req_valid_i;
    end
  end

  always_ff @(posedge clk) begin
    if (s1_ready && req_valid_i) begin
      s1_addr <= req_addr_i;
    end
  end

  // a stalled lookup keeps re-reading its own set
  assign rd_idx_o = s1_ready ? req_addr_i[`ICACHE_OFS_W +: `ICACHE_IDX_W]
                             : s1_addr[`ICACHE_OFS_W +: `ICACHE_IDX_W];

  // ==========================================================================
  // tag match and response
  // ==========================================================================
  assign s1_tag  = s1_addr[`ICACHE_ADDR_W-1 -: `ICACHE_TAG_W];
  assign s1_word = s1_addr[`ICACHE_OFS_W-1:2];

  always_comb begin
    hit_way = '0;
    for (int w = 0; w < `ICACHE_WAY_NUM; w++) begin
      way_match[w] = way_valid_i[w] && (way_tag_i[w] == s1_tag);
    end
    // lowest matching way wins
    for (int w = `ICACHE_WAY_NUM - 1; w >= 0; w--) begin
      if (way_match[w]) begin
        hit_way = way_t'(w);
      end
    end
  end

  assign hit      = |way_match;
  assign hit_line = way_line_i[hit_way];

  assign rsp_valid_o = s1_valid && hit;
  assign rsp_addr_o  = s1_addr;
  assign rsp_instr_o = hit_line[s1_word * 32 +: 32];

  // bit names the next victim and moves off the way just used
  assign repl_we_o    = s1_valid && hit && (repl_bit_i == hit_way);
  assign repl_wdata_o = ~repl_bit_i;

  assign req_ready_o   = s1_ready;
  assign s1_valid_o    = s1_valid;
  assign s1_addr_o     = s1_addr;
  assign lookup_miss_o = !hit;

endmodule

// ==== design/icache_pkg.sv ====
// icache types for addresses, words, tags, lines and the refill FSM
`include "icache_consts.svh"

package icache_pkg;

  typedef logic [`ICACHE_ADDR_W-1:0] addr_t;
  typedef logic [31:0]               instr_t;
  typedef logic [`ICACHE_TAG_W-1:0]  tag_t;
  typedef logic [`ICACHE_IDX_W-1:0]  idx_t;

  // word within a line, from address bits [3:2]
  typedef logic [$clog2(`ICACHE_LINE_WORDS)-1:0] word_sel_t;

  // one bit is enough while the cache has two ways
  typedef logic way_t;

  // word 0 sits in the low bits
  typedef logic [`ICACHE_LINE_WORDS*32-1:0] line_t;

  typedef enum logic [1:0] {
    REFILL_IDLE,
    REFILL_MISS,
    REFILL_BURST
  } refill_state_e;

endpackage

// ==== design/icache_consts.svh ====
// icache geometry constants shared by the package and the RTL blocks
`ifndef ICACHE_CONSTS_SVH
`define ICACHE_CONSTS_SVH

// fetch address width in bits
`define ICACHE_ADDR_W     32

// two ways, one replacement bit per set
`define ICACHE_WAY_NUM    2
`define ICACHE_SETS       16
`define ICACHE_IDX_W      4

// 16-byte lines of four 32-bit words
`define ICACHE_OFS_W      4
`define ICACHE_LINE_WORDS 4
`define ICACHE_TAG_W      24

`endif
